// File: ifu_pkg.sv
`default_nettype none

package ifu_pkg;

  // Bus and datapath widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // Cache geometry, sizes given as log2
  localparam int LINE_LEN = 1;  // Two words per line
  localparam int IDX_LEN = 2;  // Four lines
  localparam int LINE_WORDS = 2 ** LINE_LEN;
  localparam int NUM_LINES = 2 ** IDX_LEN;

  // Whatever is left above index, word offset and byte offset
  localparam int TAG_W = ADDR_W - IDX_LEN - LINE_LEN - 2;

  localparam logic [ADDR_W-1:0] PC_INIT = 32'h8000_0000;

  // fence.i with rd, rs1 and imm all zero
  localparam logic [DATA_W-1:0] INST_FENCE_I = 32'h0000_100f;

  // RV32I major opcodes, bits [6:0] of the instruction
  typedef enum logic [6:0] {
    OP_LOAD     = 7'b000_0011,
    OP_MISC_MEM = 7'b000_1111,  // fence, fence.i
    OP_OP_IMM   = 7'b001_0011,
    OP_STORE    = 7'b010_0011,
    OP_OP       = 7'b011_0011,
    OP_BRANCH   = 7'b110_0011,
    OP_JALR     = 7'b110_0111,
    OP_JAL      = 7'b110_1111,
    OP_SYSTEM   = 7'b111_0011   // ecall, ebreak, csr ops
  } opcode_e;

  // How the fetch controller continues after handing a word downstream
  typedef enum logic [1:0] {
    CLS_SEQ    = 2'd0,  // Fall through to PC+4
    CLS_BRANCH = 2'd1,  // Wait for a redirect
    CLS_LOAD   = 2'd2   // Wait for the load to retire
  } fetch_class_e;

  // Cache refill sequence, one pass per missed line
  typedef enum logic [2:0] {
    RF_IDLE  = 3'd0,
    RF_BEAT0 = 3'd1,
    RF_GAP   = 3'd2,
    RF_BEAT1 = 3'd3,
    RF_DONE  = 3'd4
  } refill_state_e;

endpackage

`default_nettype wire

// File: l1i_lookup_if.sv
`default_nettype none

interface l1i_lookup_if;
  import ifu_pkg::*;

  logic [ADDR_W-1:0] pc;  // Current fetch PC
  logic              hit;
  logic [DATA_W-1:0] inst;

  // One-cycle pulse, the cache drops every line on the next edge
  logic              flush;

  modport ctrl (
    output pc,
    output flush,
    input  hit,
    input  inst
  );

  modport cache (
    input  pc,
    input  flush,
    output hit,
    output inst
  );

endinterface

`default_nettype wire

// File: l1i_cache.sv
`default_nettype none

module l1i_cache (
  input  logic                         clk,
  input  logic                         rst,

  l1i_lookup_if.cache                  lookup,

  output logic [ifu_pkg::ADDR_W-1:0]   bus_araddr_o,
  output logic                         bus_arvalid_o,
  output logic                         bus_required_o,
  input  logic [ifu_pkg::DATA_W-1:0]   bus_rdata_i,
  input  logic                         bus_rvalid_i
);
  import ifu_pkg::*;

  // Every word slot keeps its own tag, valid is per line
  logic [DATA_W-1:0]    data_mem [NUM_LINES][LINE_WORDS];
  logic [TAG_W-1:0]     tag_mem  [NUM_LINES][LINE_WORDS];
  logic [NUM_LINES-1:0] line_valid;

  refill_state_e state_q;
  refill_state_e state_d;

  // Tag and index of the line being refilled
  logic [TAG_W+IDX_LEN-1:0] refill_line_q;

  logic [TAG_W-1:0]    pc_tag;
  logic [IDX_LEN-1:0]  pc_idx;
  logic [LINE_LEN-1:0] pc_off;
  logic [TAG_W-1:0]    fill_tag;
  logic [IDX_LEN-1:0]  fill_idx;

  logic lookup_open;
  logic slot_match;
  logic beat0_done;
  logic beat1_done;

  // Address split: tag | index | word offset | byte offset
  assign pc_tag = lookup.pc[ADDR_W-1 -: TAG_W];
  assign pc_idx = lookup.pc[LINE_LEN+2 +: IDX_LEN];
  assign pc_off = lookup.pc[2 +: LINE_LEN];

  assign fill_tag = refill_line_q[IDX_LEN +: TAG_W];
  assign fill_idx = refill_line_q[IDX_LEN-1:0];

  // Slots are half written while a refill runs, so a hit only counts outside it
  assign lookup_open = (state_q == RF_IDLE) || (state_q == RF_DONE);
  assign slot_match  = line_valid[pc_idx] && (tag_mem[pc_idx][pc_off] == pc_tag);

  assign lookup.hit  = lookup_open && slot_match;
  assign lookup.inst = data_mem[pc_idx][pc_off];

  assign beat0_done = (state_q == RF_BEAT0) && bus_rvalid_i;
  assign beat1_done = (state_q == RF_BEAT1) && bus_rvalid_i;

  // Beat 0 fetches the line base, beat 1 the second word
  always_comb begin
    case (state_q)
      RF_IDLE: begin
        bus_araddr_o = {lookup.pc[ADDR_W-1:LINE_LEN+2], {LINE_LEN{1'b0}}, 2'b00};
      end
      RF_BEAT0: begin
        bus_araddr_o = {refill_line_q, {LINE_LEN{1'b0}}, 2'b00};
      end
      default: begin
        bus_araddr_o = {refill_line_q, LINE_LEN'(1), 2'b00};
      end
    endcase
  end

  // Held while a beat is outstanding, low in the gap and in the done cycle
  assign bus_arvalid_o = ((state_q == RF_IDLE) && !slot_match) ||
                         (state_q == RF_BEAT0) ||
                         (state_q == RF_BEAT1);

  assign bus_required_o = (state_q != RF_IDLE);

  always_comb begin
    state_d = state_q;
    case (state_q)
      RF_IDLE: begin
        if (!slot_match) begin
          state_d = RF_BEAT0;
        end
      end
      RF_BEAT0: begin
        if (bus_rvalid_i) begin
          state_d = RF_GAP;
        end
      end
      RF_GAP:   state_d = RF_BEAT1;  // One idle cycle between the two beats
      RF_BEAT1: begin
        if (bus_rvalid_i) begin
          state_d = RF_DONE;
        end
      end
      RF_DONE:  state_d = RF_IDLE;
      default:  state_d = RF_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= RF_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Sampled every idle cycle, so it holds the missed line once the refill starts
  always_ff @(posedge clk) begin
    if (state_q == RF_IDLE) begin
      refill_line_q <= lookup.pc[ADDR_W-1:LINE_LEN+2];
    end
  end

  always_ff @(posedge clk) begin
    if (beat0_done) begin
      data_mem[fill_idx][0] <= bus_rdata_i;
      tag_mem[fill_idx][0]  <= fill_tag;
    end
    if (beat1_done) begin
      data_mem[fill_idx][1] <= bus_rdata_i;
      tag_mem[fill_idx][1]  <= fill_tag;
    end
  end

  // A flush only comes with a hit, never in the beat 1 cycle
  always_ff @(posedge clk) begin
    if (rst || lookup.flush) begin
      line_valid <= '0;
    end else if (beat1_done) begin
      line_valid[fill_idx] <= 1'b1;  // Both words are in now
    end
  end

endmodule

`default_nettype wire

// File: fetch_ctrl.sv
`default_nettype none

module fetch_ctrl (
  input  logic                         clk,
  input  logic                         rst,

  l1i_lookup_if.ctrl                   lookup,

  // Downstream stage
  output logic [ifu_pkg::DATA_W-1:0]   inst_o,
  output logic [ifu_pkg::DATA_W-1:0]   pc_o,
  output logic                         valid_o,
  output logic                         ready_o,
  input  logic                         next_ready_i,

  // Back end
  input  logic [ifu_pkg::ADDR_W-1:0]   npc_i,
  input  logic                         pc_change_i,
  input  logic                         pc_retire_i
);
  import ifu_pkg::*;

  logic [ADDR_W-1:0] pc_q;
  logic [ADDR_W-1:0] pc_d;
  logic              stall_q;  // Waiting on the back end
  logic              stall_d;

  logic [ADDR_W-1:0] pc_seq;
  opcode_e           opcode;
  fetch_class_e      fetch_class;
  logic              fire;

  assign lookup.pc = pc_q;
  assign pc_seq    = pc_q + ADDR_W'(4);

  // The word on inst_o comes straight from the cache slot of pc_q
  assign inst_o  = lookup.inst;
  assign pc_o    = pc_q;
  assign valid_o = lookup.hit && !stall_q;
  assign ready_o = !valid_o;

  assign fire = valid_o && next_ready_i;

  assign opcode = opcode_e'(lookup.inst[6:0]);

  // Only control flow and loads need the back end before fetch can go on
  always_comb begin
    case (opcode)
      OP_JAL, OP_JALR, OP_BRANCH, OP_SYSTEM: begin
        fetch_class = CLS_BRANCH;
      end
      OP_LOAD: begin
        fetch_class = CLS_LOAD;
      end
      OP_STORE, OP_OP, OP_OP_IMM, OP_MISC_MEM: begin
        fetch_class = CLS_SEQ;
      end
      default: begin
        fetch_class = CLS_SEQ;  // Unknown opcodes just flow through
      end
    endcase
  end

  // fence.i drops the cache as it leaves, so the next fetch misses
  assign lookup.flush = fire && (lookup.inst == INST_FENCE_I);

  always_comb begin
    pc_d    = pc_q;
    stall_d = stall_q;

    if (stall_q) begin
      // A redirect wins over a retire
      if (pc_change_i) begin
        pc_d    = npc_i;
        stall_d = 1'b0;
      end else if (pc_retire_i) begin
        pc_d    = pc_seq;
        stall_d = 1'b0;
      end
    end else if (fire) begin
      if (fetch_class == CLS_SEQ) begin
        pc_d = pc_seq;
      end else begin
        stall_d = 1'b1;  // PC stays on the branch or load
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q    <= PC_INIT;
      stall_q <= 1'b0;
    end else begin
      pc_q    <= pc_d;
      stall_q <= stall_d;
    end
  end

endmodule

`default_nettype wire

// File: ifu_top.sv
`default_nettype none

module ifu_top (
  input  logic                         clk,
  input  logic                         rst,

  // Instruction read bus
  output logic [ifu_pkg::ADDR_W-1:0]   bus_araddr_o,
  output logic                         bus_arvalid_o,
  output logic                         bus_required_o,
  input  logic [ifu_pkg::DATA_W-1:0]   bus_rdata_i,
  input  logic                         bus_rvalid_i,

  // Downstream stage
  output logic [ifu_pkg::DATA_W-1:0]   inst_o,
  output logic [ifu_pkg::DATA_W-1:0]   pc_o,
  output logic                         valid_o,
  output logic                         ready_o,
  input  logic                         next_ready_i,

  // Back end
  input  logic [ifu_pkg::ADDR_W-1:0]   npc_i,
  input  logic                         pc_change_i,
  input  logic                         pc_retire_i
);

  l1i_lookup_if lookup_if ();

  l1i_cache u_l1i_cache (
    .clk            (clk),
    .rst            (rst),
    .lookup         (lookup_if.cache),
    .bus_araddr_o   (bus_araddr_o),
    .bus_arvalid_o  (bus_arvalid_o),
    .bus_required_o (bus_required_o),
    .bus_rdata_i    (bus_rdata_i),
    .bus_rvalid_i   (bus_rvalid_i)
  );

  fetch_ctrl u_fetch_ctrl (
    .clk          (clk),
    .rst          (rst),
    .lookup       (lookup_if.ctrl),
    .inst_o       (inst_o),
    .pc_o         (pc_o),
    .valid_o      (valid_o),
    .ready_o      (ready_o),
    .next_ready_i (next_ready_i),
    .npc_i        (npc_i),
    .pc_change_i  (pc_change_i),
    .pc_retire_i  (pc_retire_i)
  );

endmodule

`default_nettype wire

// File: tb_ifu_model.svh
localparam int          IMG_WORDS    = 64;
localparam logic [31:0] IMG_BASE     = 32'h8000_0000;
localparam logic [31:0] FENCE_I_WORD = 32'h0000_100f;
localparam int          KIND_SEQ     = 0;
localparam int          KIND_BRANCH  = 1;  // Waits for a redirect
localparam int          KIND_LOAD    = 2;  // Waits for a retire

logic [31:0] image [IMG_WORDS];
logic [31:0] exp_pc;  // PC of the next transfer
int unsigned arvalid_rises;
logic        arvalid_prev;

// Random program with the given mix in percent, the rest are plain ALU and store words
task automatic gen_image(input int unsigned pct_branch, input int unsigned pct_load,
                         input int unsigned pct_fence, input bit close_jal);
  logic [6:0]  seq_ops [3];
  logic [6:0]  ctl_ops [4];
  int unsigned roll;
  logic [24:0] upper;
  seq_ops = '{7'h33, 7'h13, 7'h23};
  ctl_ops = '{7'h6f, 7'h67, 7'h63, 7'h73};
  for (int i = 0; i < IMG_WORDS; i++) begin
    roll  = $urandom_range(99, 0);
    upper = 25'($urandom);
    if (roll < pct_branch) begin
      image[i] = {upper, ctl_ops[$urandom_range(3, 0)]};
    end else if (roll < pct_branch + pct_load) begin
      image[i] = {upper, 7'h03};
    end else if (roll < pct_branch + pct_load + pct_fence) begin
      image[i] = FENCE_I_WORD;
    end else begin
      image[i] = {upper, seq_ops[$urandom_range(2, 0)]};
    end
  end
  if (close_jal) begin
    image[IMG_WORDS-1] = {upper, 7'h6f};  // Fetch never runs past the last word
  end
endtask

// Outside the image memory returns ALU words built from the address
function automatic logic [31:0] mem_word(input logic [31:0] addr);
  logic [31:0] offs;
  offs = addr - IMG_BASE;
  if (offs < 32'(IMG_WORDS * 4)) begin
    return image[offs[7:2]];
  end
  return {addr[31:7] ^ addr[26:2], 7'h13};
endfunction

function automatic int word_kind(input logic [31:0] word);
  case (word[6:0])
    7'h6f, 7'h67, 7'h63, 7'h73: return KIND_BRANCH;  // jal, jalr, branch, system
    7'h03: return KIND_LOAD;
    default: return KIND_SEQ;
  endcase
endfunction

task automatic count_reset();
  arvalid_rises = 0;
  arvalid_prev  = 1'b0;
endtask

task automatic count_sample();
  if (bus_arvalid_o && !arvalid_prev) begin
    arvalid_rises++;
  end
  arvalid_prev = bus_arvalid_o;
endtask

// A finished refill must have read the line base and then the word after it
task automatic check_beats(input string test, input logic [31:0] base);
  if (beat_q.size() != 2) begin
    report_mismatch(test, "refill beat count", 32'd2, 32'(beat_q.size()));
  end else begin
    if (beat_q[0] != base) begin
      report_mismatch(test, "beat 0 address", base, beat_q[0]);
    end
    if (beat_q[1] != base + 32'd4) begin
      report_mismatch(test, "beat 1 address", base + 32'd4, beat_q[1]);
    end
  end
  beat_q.delete();
endtask

// File: tb_ifu.sv
`default_nettype none

module tb_ifu;
  localparam int TIMEOUT = 200;  // Cycles without a transfer before a test gives up

  logic        clk;
  logic        rst;
  logic [31:0] bus_araddr_o;
  logic        bus_arvalid_o;
  logic        bus_required_o;
  logic [31:0] bus_rdata_i = '0;
  logic        bus_rvalid_i = 1'b0;
  logic [31:0] inst_o;
  logic [31:0] pc_o;
  logic        valid_o;
  logic        ready_o;
  logic        next_ready_i;
  logic [31:0] npc_i;
  logic        pc_change_i;
  logic        pc_retire_i;

  logic [31:0] beat_q [$];  // Beat addresses of the refill in progress
  int          mem_wait = -1;
  logic        mem_serve;
  logic [31:0] mem_addr;
  int unsigned err_cnt;
  int unsigned tests_run;
  int unsigned tests_failed;

  task automatic report_mismatch(input string test, input string what,
                                 input logic [31:0] expected, input logic [31:0] actual);
    $display("Mismatch %s %s: expected %h, actual %h", test, what, expected, actual);
    err_cnt++;
  endtask

  task automatic report_error(input string test, input string what);
    $display("Error %s: %s", test, what);
    err_cnt++;
  endtask

  `include "tb_ifu_model.svh"

  ifu_top u_ifu_top (
    .clk            (clk),
    .rst            (rst),
    .bus_araddr_o   (bus_araddr_o),
    .bus_arvalid_o  (bus_arvalid_o),
    .bus_required_o (bus_required_o),
    .bus_rdata_i    (bus_rdata_i),
    .bus_rvalid_i   (bus_rvalid_i),
    .inst_o         (inst_o),
    .pc_o           (pc_o),
    .valid_o        (valid_o),
    .ready_o        (ready_o),
    .next_ready_i   (next_ready_i),
    .npc_i          (npc_i),
    .pc_change_i    (pc_change_i),
    .pc_retire_i    (pc_retire_i)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Memory answers each outstanding beat after a random wait
  always begin
    @(negedge clk);
    mem_serve = 1'b0;
    if (rst) begin
      mem_wait = -1;
    end else if (bus_arvalid_o && bus_required_o && !bus_rvalid_i) begin
      if (mem_wait < 0) begin
        mem_wait = int'($urandom_range(5, 0));
      end
      if (mem_wait == 0) begin
        mem_serve = 1'b1;
        mem_addr  = bus_araddr_o;
        mem_wait  = -1;
      end else begin
        mem_wait--;
      end
    end
    @(posedge clk);
    #1;
    bus_rvalid_i = mem_serve;
    if (mem_serve) begin
      bus_rdata_i = mem_word(mem_addr);
      beat_q.push_back(mem_addr);
    end
  end

  task automatic apply_reset();
    @(posedge clk);
    #1;
    rst          = 1'b1;
    next_ready_i = 1'b0;
    pc_change_i  = 1'b0;
    pc_retire_i  = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;
  endtask

  // Drives a random consumer and back end around the DUT and checks every transfer
  task automatic run_test(input string name, input int unsigned n_xfer,
                          input int unsigned target_words, input bit loop_check);
    int unsigned xfers;
    int unsigned idle;
    int unsigned errs_start;
    int unsigned bk_wait;
    int unsigned tgt;
    int unsigned loop_mark;
    int unsigned fence_mark;
    int          stall_kind;
    bit          stalled;
    bit          pulse_on;
    bit          hold;
    bit          loop_armed;
    bit          fence_pending;
    bit          req_prev;
    logic [31:0] hold_pc;
    logic [31:0] hold_inst;
    logic [31:0] exp_inst;
    logic [31:0] refill_base;
    xfers         = 0;
    idle          = 0;
    errs_start    = err_cnt;
    stalled       = 0;
    pulse_on      = 0;
    hold          = 0;
    loop_armed    = 0;
    fence_pending = 0;
    req_prev      = 0;
    refill_base   = '0;
    exp_pc        = IMG_BASE;
    count_reset();
    beat_q.delete();
    while (xfers < n_xfer && idle < TIMEOUT) begin
      @(negedge clk);
      idle++;
      count_sample();
      if (ready_o !== !valid_o) begin
        report_mismatch(name, "ready_o", {31'b0, !valid_o}, {31'b0, ready_o});
      end
      if (bus_required_o && !req_prev) begin
        refill_base = {exp_pc[31:3], 3'b000};
      end
      if (!bus_required_o && req_prev) begin
        check_beats(name, refill_base);
      end
      req_prev = bus_required_o;
      if (hold) begin
        if (!valid_o) begin
          report_error(name, "valid_o dropped while the consumer held it off");
        end
        if (pc_o !== hold_pc) begin
          report_mismatch(name, "held pc_o", hold_pc, pc_o);
        end
        if (inst_o !== hold_inst) begin
          report_mismatch(name, "held inst_o", hold_inst, inst_o);
        end
      end
      if (stalled && valid_o) begin
        report_error(name, "valid_o rose before the back end answered");
      end
      if (pulse_on) begin
        stalled = 0;
      end
      if (valid_o && next_ready_i) begin
        idle     = 0;
        xfers++;
        exp_inst = mem_word(exp_pc);
        if (pc_o !== exp_pc) begin
          report_mismatch(name, "pc_o", exp_pc, pc_o);
        end
        if (inst_o !== exp_inst) begin
          report_mismatch(name, "inst_o", exp_inst, inst_o);
        end
        if (fence_pending && arvalid_rises == fence_mark) begin
          report_error(name, "no refill request after fence.i");
        end
        fence_pending = (exp_inst == FENCE_I_WORD);
        fence_mark    = arvalid_rises;
        stall_kind    = word_kind(exp_inst);
        if (stall_kind == KIND_SEQ) begin
          exp_pc = exp_pc + 32'd4;
        end else begin
          stalled = 1;
          bk_wait = $urandom_range(4, 0);
          if (loop_check && !loop_armed) begin
            loop_armed = 1;  // All loop lines are resident by now
            loop_mark  = arvalid_rises;
          end
        end
      end
      hold      = valid_o && !next_ready_i;
      hold_pc   = pc_o;
      hold_inst = inst_o;

      @(posedge clk);
      #1;
      pc_change_i  = 1'b0;
      pc_retire_i  = 1'b0;
      pulse_on     = 0;
      next_ready_i = ($urandom_range(3, 0) != 0);
      if (stalled && bk_wait == 0) begin
        pulse_on = 1;
        if (stall_kind == KIND_BRANCH) begin
          tgt         = $urandom_range(target_words - 1, 0);
          npc_i       = IMG_BASE + (tgt << 2);
          pc_change_i = 1'b1;
          exp_pc      = npc_i;
        end else begin
          pc_retire_i = 1'b1;
          exp_pc      = exp_pc + 32'd4;
        end
      end else if (stalled) begin
        bk_wait--;
      end
    end
    if (idle >= TIMEOUT) begin
      report_error(name, "timed out waiting for the next transfer");
    end
    if (loop_check && !loop_armed) begin
      report_error(name, "the loop never reached its closing branch");
    end else if (loop_check && arvalid_rises != loop_mark) begin
      report_mismatch(name, "bus_arvalid_o rises", 32'(loop_mark), 32'(arvalid_rises));
    end
    tests_run++;
    if (err_cnt == errs_start) begin
      $display("%s: ok, %0d transfers", name, xfers);
    end else begin
      tests_failed++;
      $display("%s: FAILED with %0d errors", name, err_cnt - errs_start);
    end
  endtask

  initial begin
    rst          = 1'b1;
    next_ready_i = 1'b0;
    npc_i        = '0;
    pc_change_i  = 1'b0;
    pc_retire_i  = 1'b0;
    err_cnt      = 0;
    tests_run    = 0;
    tests_failed = 0;
    void'($urandom(32'hdc23));

    gen_image(0, 0, 0, 1'b0);
    apply_reset();
    run_test("seq_stream", 60, IMG_WORDS, 1'b0);

    gen_image(20, 0, 0, 1'b1);
    apply_reset();
    run_test("branch_redirect", 80, IMG_WORDS, 1'b0);

    gen_image(10, 20, 0, 1'b1);
    apply_reset();
    run_test("load_retire", 80, IMG_WORDS, 1'b0);

    // Eight words fill all four lines and a jal at word 7 loops back into them
    gen_image(0, 0, 0, 1'b0);
    image[7] = 32'h0000_006f;
    apply_reset();
    run_test("refill_loop", 60, 8, 1'b1);

    gen_image(10, 5, 15, 1'b1);
    apply_reset();
    run_test("fence_i", 80, IMG_WORDS, 1'b0);

    gen_image(12, 12, 5, 1'b1);
    apply_reset();
    run_test("random_run", 300, IMG_WORDS, 1'b0);

    $display("Summary: %0d run, %0d ok, %0d failing, %0d errors",
             tests_run, tests_run - tests_failed, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
+incdir+.
ifu_pkg.sv
l1i_lookup_if.sv
l1i_cache.sv
fetch_ctrl.sv
ifu_top.sv
tb_ifu.sv

// File: run.sh
#!/bin/sh
# Build and run the fetch unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --top-module tb_ifu -f project.f

out=$(./obj_dir/Vtb_ifu)
echo "$out"

# Exit status follows the verdict line of the testbench
echo "$out" | grep -qx "test passed"
